//--- pcs_line_pkg.sv
`default_nettype none

package pcs_line_pkg;

	//////////////////////////////////////////////////////////////////////
	// Code group and config word types

	typedef logic [7:0] byte_t;			// Payload of one code group
	typedef logic [15:0] config_word_t;	// Clause-37 or SGMII config register

	// One 8b/10b code group after decoding
	typedef struct packed {
		logic	is_ctl;		// K character when set
		byte_t	data;
	} code_group_t;

	//////////////////////////////////////////////////////////////////////
	// Special characters

	localparam byte_t k28_5 = 8'hbc;	// Comma, first group of every ordered set
	localparam byte_t d21_5 = 8'hb5;	// /C1/ header
	localparam byte_t d2_2 = 8'h42;		// /C2/ header
	localparam byte_t d16_2 = 8'h50;	// /I2/ header
	localparam byte_t d5_6 = 8'hc5;		// /I1/ header
	localparam byte_t k27_7 = 8'hfb;	// /S/ start of packet
	localparam byte_t k29_7 = 8'hfd;	// /T/ end of packet

	// Config word bit positions
	localparam int cfg_bit_link = 15;	// SGMII link status from the PHY
	localparam int cfg_bit_ack = 14;	// Acknowledge
	localparam int cfg_speed_lo = 10;	// SGMII speed field, two bits
	localparam int cfg_bit_fd = 5;		// 1000BASE-X full duplex
	localparam int cfg_bit_sgmii = 0;	// Always set in SGMII words

	// Local abilities
	localparam config_word_t ability_basex = 16'h0020;	// Full duplex, no pause
	localparam config_word_t ability_sgmii = 16'h4001;	// ACK plus SGMII marker

	// Ability match ignores the ACK bit
	localparam config_word_t cfg_mask_no_ack = ~(config_word_t'(1) << cfg_bit_ack);

endpackage

`default_nettype wire

//--- pcs_link_pkg.sv
`default_nettype none

package pcs_link_pkg;

	//////////////////////////////////////////////////////////////////////
	// Link status

	// Same coding as the SGMII speed field
	typedef enum logic [1:0] {
		link_speed_10m = 2'b00,
		link_speed_100m = 2'b01,
		link_speed_1000m = 2'b10
	} lspeed_t;

	// Simplified clause-37 arbitration states
	typedef enum logic [2:0] {
		aneg_enable = 3'h0,
		aneg_restart = 3'h1,
		aneg_ability_detect = 3'h2,
		aneg_ack_detect = 3'h3,
		aneg_complete_ack = 3'h4,
		aneg_idle_detect = 3'h5,
		aneg_link_up = 3'h6
	} aneg_state_t;

	//////////////////////////////////////////////////////////////////////
	// GMII side

	typedef struct packed {
		logic					en;		// Byte valid
		logic					er;		// Byte in error
		pcs_line_pkg::byte_t	data;
	} gmii_bus_t;

	localparam pcs_line_pkg::byte_t gmii_preamble = 8'h55;	// Replaces /S/

	//////////////////////////////////////////////////////////////////////
	// Link timer

	typedef logic [31:0] timer_t;

	// Cycles at 125 MHz, minus one
	localparam timer_t link_timer_sgmii_default = 32'd199999;	// 1.6 ms
	localparam timer_t link_timer_basex_default = 32'd1249999;	// 10 ms

endpackage

`default_nettype wire

//--- rx_cdc_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module rx_cdc_fifo #(
	parameter int depth = 32					// Entries, power of two
) (
	input wire							wr_clk,		// SERDES recovered clock
	input wire							wr_en,
	input wire pcs_line_pkg::code_group_t	wr_data,
	input wire							rd_clk,		// clk_125mhz
	input wire							reset,		// rd_clk domain
	output pcs_line_pkg::code_group_t	rd_data,
	output logic						rd_valid,
	output logic						overflow	// wr_clk domain strobe
);
	import pcs_line_pkg::*;

	localparam int addr_bits = $clog2(depth);

	typedef logic [addr_bits:0] ptr_t;		// Extra MSB tells full from empty

	code_group_t	mem [depth];

	// Gray to binary, MSB down
	function automatic ptr_t gray_to_bin(input ptr_t gray);
		ptr_t bin;
		bin[addr_bits] = gray[addr_bits];
		for (int i = addr_bits - 1; i >= 0; i--)
			bin[i] = bin[i + 1] ^ gray[i];
		return bin;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Write side

	logic [1:0]	wr_reset_sync;			// Reset into wr_clk
	logic		wr_reset;
	ptr_t		wr_bin;
	ptr_t		wr_bin_next;
	ptr_t		wr_gray;
	ptr_t		rd_gray;				// Read pointer, rd_clk domain
	ptr_t		rd_gray_meta;			// First sync flop
	ptr_t		rd_gray_wr;				// Second sync flop
	ptr_t		rd_bin_wr;
	logic		full;

	assign wr_reset = wr_reset_sync[1];
	assign wr_bin_next = wr_bin + 1'b1;
	assign rd_bin_wr = gray_to_bin(rd_gray_wr);
	assign full = (wr_bin[addr_bits] != rd_bin_wr[addr_bits]) &&
		(wr_bin[addr_bits-1:0] == rd_bin_wr[addr_bits-1:0]);

	always_ff @(posedge wr_clk)
		wr_reset_sync <= {wr_reset_sync[0], reset};

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			wr_bin <= '0;
			wr_gray <= '0;
			rd_gray_meta <= '0;
			rd_gray_wr <= '0;
			overflow <= 1'b0;
		end else begin
			rd_gray_meta <= rd_gray;
			rd_gray_wr <= rd_gray_meta;
			overflow <= 1'b0;
			if (wr_en && full)
				overflow <= 1'b1;		// Group lost, SERDES cannot be held off
			else if (wr_en) begin
				wr_bin <= wr_bin_next;
				wr_gray <= (wr_bin_next >> 1) ^ wr_bin_next;
			end
		end
	end

	always_ff @(posedge wr_clk) begin
		if (wr_en && !full)
			mem[wr_bin[addr_bits-1:0]] <= wr_data;
	end

	//////////////////////////////////////////////////////////////////////
	// Read side

	ptr_t		rd_bin;
	ptr_t		rd_bin_next;
	ptr_t		wr_gray_meta;
	ptr_t		wr_gray_rd;
	ptr_t		wr_bin_rd;
	logic		empty;

	assign rd_bin_next = rd_bin + 1'b1;
	assign wr_bin_rd = gray_to_bin(wr_gray_rd);
	assign empty = (rd_bin == wr_bin_rd);		// Read whenever this is low

	always_ff @(posedge rd_clk) begin
		if (reset) begin
			rd_bin <= '0;
			rd_gray <= '0;
			wr_gray_meta <= '0;
			wr_gray_rd <= '0;
			rd_valid <= 1'b0;
		end else begin
			wr_gray_meta <= wr_gray;
			wr_gray_rd <= wr_gray_meta;
			rd_valid <= !empty;				// Matches the registered rd_data
			if (!empty) begin
				rd_bin <= rd_bin_next;
				rd_gray <= (rd_bin_next >> 1) ^ rd_bin_next;
			end
		end
	end

	always_ff @(posedge rd_clk) begin
		if (!empty)
			rd_data <= mem[rd_bin[addr_bits-1:0]];
	end

endmodule

`default_nettype wire

//--- rx_ordered_set_parser.sv
`default_nettype none
`timescale 1ns/10ps

module rx_ordered_set_parser (
	input wire							clk_125mhz,
	input wire							reset,
	input wire pcs_line_pkg::code_group_t	rx_group,
	input wire							rx_valid,
	input wire							link_up,
	output pcs_line_pkg::config_word_t	partner_cfg,	// Last word received
	output logic						cfg_valid,		// One cycle per /C/
	output logic						idle_seen		// One cycle per /I/
);
	import pcs_line_pkg::*;

	typedef enum logic [1:0] {
		ps_wait_comma,
		ps_header,
		ps_cfg_lo,
		ps_cfg_hi
	} parse_state_t;

	parse_state_t	state;
	byte_t			cfg_lo;			// Low byte, waits for the high one
	logic			is_comma;
	logic			is_cfg_hdr;
	logic			is_idle_hdr;

	assign is_comma = rx_group.is_ctl && (rx_group.data == k28_5);
	assign is_cfg_hdr = !rx_group.is_ctl &&
		((rx_group.data == d21_5) || (rx_group.data == d2_2));		// /C1/ or /C2/
	assign is_idle_hdr = !rx_group.is_ctl &&
		((rx_group.data == d16_2) || (rx_group.data == d5_6));		// /I2/ or /I1/

	always_ff @(posedge clk_125mhz) begin
		if (reset) begin
			state <= ps_wait_comma;
			cfg_valid <= 1'b0;
			idle_seen <= 1'b0;
		end else begin
			cfg_valid <= 1'b0;
			idle_seen <= 1'b0;

			if (rx_valid) begin
				case (state)
					ps_wait_comma: begin
						if (is_comma)
							state <= ps_header;
					end

					// Either header accepted, no C1/C2 alternation check
					ps_header: begin
						if (is_cfg_hdr)
							state <= ps_cfg_lo;
						else if (is_idle_hdr) begin
							idle_seen <= 1'b1;		// Idles count in any link state
							state <= ps_wait_comma;
						end else if (is_comma)
							state <= ps_header;		// Resync on a fresh comma
						else
							state <= ps_wait_comma;
					end

					ps_cfg_lo: begin
						cfg_lo <= rx_group.data;
						if (!rx_group.is_ctl)
							state <= ps_cfg_hi;
						else
							state <= is_comma ? ps_header : ps_wait_comma;
					end

					ps_cfg_hi: begin
						state <= is_comma ? ps_header : ps_wait_comma;
						if (!rx_group.is_ctl) begin
							// While linked the word stays frozen, the strobe
							// alone restarts autonegotiation
							if (!link_up)
								partner_cfg <= {rx_group.data, cfg_lo};
							cfg_valid <= 1'b1;
						end
					end

					default: state <= ps_wait_comma;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- aneg_fsm.sv
`default_nettype none
`timescale 1ns/10ps

module aneg_fsm #(
	parameter pcs_link_pkg::timer_t link_timer_sgmii = pcs_link_pkg::link_timer_sgmii_default,
	parameter pcs_link_pkg::timer_t link_timer_basex = pcs_link_pkg::link_timer_basex_default
) (
	input wire							clk_125mhz,
	input wire							reset,
	input wire							sgmii_mode,		// 1 = SGMII, 0 = 1000BASE-X
	input wire pcs_line_pkg::config_word_t	partner_cfg,
	input wire							cfg_valid,
	input wire							idle_seen,
	output pcs_line_pkg::config_word_t	tx_cfg,			// Word for /C/ sets
	output logic						send_config,	// Low selects idles
	output logic						link_up,
	output pcs_link_pkg::lspeed_t		link_speed
);
	import pcs_line_pkg::*;
	import pcs_link_pkg::*;

	aneg_state_t	state;
	timer_t			timer_cnt;
	timer_t			timer_target;
	logic			timer_done;
	config_word_t	last_cfg;		// Previous partner word
	logic [1:0]		match_cnt;		// Identical words in a row
	logic			idle_flag;		// Idle seen during idle detect
	logic			cfg_same;
	logic			partner_zero;

	//////////////////////////////////////////////////////////////////////
	// Link timer and word compare

	assign timer_target = sgmii_mode ? link_timer_sgmii : link_timer_basex;
	assign timer_done = (timer_cnt >= timer_target);
	assign cfg_same = ((partner_cfg ^ last_cfg) & cfg_mask_no_ack) == '0;
	assign partner_zero = (partner_cfg == '0);		// Partner restarting

	//////////////////////////////////////////////////////////////////////
	// Arbitration

	always_ff @(posedge clk_125mhz) begin
		if (reset) begin
			state <= aneg_enable;
			timer_cnt <= '0;
			match_cnt <= '0;
			idle_flag <= 1'b0;
			tx_cfg <= '0;
			send_config <= 1'b1;
			link_up <= 1'b0;
			link_speed <= link_speed_1000m;
		end else begin
			if (!timer_done)
				timer_cnt <= timer_cnt + 1'b1;		// Holds at target
			if (cfg_valid)
				last_cfg <= partner_cfg;

			case (state)
				aneg_enable: begin
					tx_cfg <= '0;
					send_config <= 1'b1;
					link_up <= 1'b0;
					timer_cnt <= '0;
					state <= aneg_restart;
				end

				// Config 0 for one link timer
				aneg_restart: begin
					match_cnt <= '0;
					if (timer_done) begin
						tx_cfg <= sgmii_mode ? ability_sgmii : ability_basex;
						state <= aneg_ability_detect;
					end
				end

				aneg_ability_detect: begin
					if (cfg_valid) begin
						if (partner_zero)
							state <= aneg_enable;
						else if ((match_cnt != 2'd0) && cfg_same) begin
							match_cnt <= match_cnt + 1'b1;
							if (match_cnt == 2'd2) begin		// Third in a row
								tx_cfg[cfg_bit_ack] <= 1'b1;
								state <= aneg_ack_detect;
							end
						end else
							match_cnt <= 2'd1;
					end
				end

				// Same abilities, now with ACK
				aneg_ack_detect: begin
					if (cfg_valid) begin
						if (partner_zero)
							state <= aneg_enable;
						else if (partner_cfg[cfg_bit_ack] && cfg_same) begin
							timer_cnt <= '0;
							state <= aneg_complete_ack;
						end
					end
				end

				aneg_complete_ack: begin
					if (cfg_valid && partner_zero)
						state <= aneg_enable;
					else if (timer_done) begin
						send_config <= 1'b0;			// Switch TX to idles
						timer_cnt <= '0;
						idle_flag <= 1'b0;
						state <= aneg_idle_detect;
					end
				end

				// Full link timer plus at least one partner idle
				aneg_idle_detect: begin
					if (idle_seen)
						idle_flag <= 1'b1;
					if (timer_done && (idle_flag || idle_seen)) begin
						link_up <= 1'b1;
						if (sgmii_mode)
							link_speed <= lspeed_t'(last_cfg[cfg_speed_lo +: 2]);
						else
							link_speed <= link_speed_1000m;
						state <= aneg_link_up;
					end
				end

				aneg_link_up: begin
					if (cfg_valid) begin			// Any /C/ drops the link
						link_up <= 1'b0;
						state <= aneg_enable;
					end
				end

				default: state <= aneg_enable;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- tx_code_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tx_code_gen (
	input wire							clk_125mhz,
	input wire							reset,
	input wire pcs_line_pkg::config_word_t	tx_cfg,
	input wire							send_config,
	output pcs_line_pkg::code_group_t	tx_group		// To SERDES, registered
);
	import pcs_line_pkg::*;

	logic [2:0]		pos;			// Place in the /C1/ /C2/ pair
	logic			cfg_mode;		// Mode of the set in progress
	logic			mode_now;
	config_word_t	cfg_hold;		// Word of the current set, no tearing

	// New mode only where a set begins
	assign mode_now = (pos[1:0] == 2'd0) ? send_config : cfg_mode;

	always_ff @(posedge clk_125mhz) begin
		if (reset) begin
			pos <= 3'd1;					// Reset output is position 0
			cfg_mode <= 1'b1;
			tx_group <= {1'b1, k28_5};
		end else begin
			pos <= pos + 1'b1;
			cfg_mode <= mode_now;
			tx_group.is_ctl <= 1'b0;

			if (mode_now) begin
				case (pos)
					3'd0, 3'd4: begin
						tx_group.is_ctl <= 1'b1;
						tx_group.data <= k28_5;
					end
					3'd1: begin
						tx_group.data <= d21_5;		// /C1/
						cfg_hold <= tx_cfg;
					end
					3'd5: begin
						tx_group.data <= d2_2;		// /C2/
						cfg_hold <= tx_cfg;
					end
					3'd2, 3'd6: tx_group.data <= cfg_hold[7:0];	// Low byte first
					default: tx_group.data <= cfg_hold[15:8];
				endcase
			end else if (!pos[0]) begin
				tx_group.is_ctl <= 1'b1;			// /I2/ comma
				tx_group.data <= k28_5;
			end else
				tx_group.data <= d16_2;
		end
	end

endmodule

`default_nettype wire

//--- rx_frame_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module rx_frame_decoder (
	input wire							clk_125mhz,
	input wire							reset,
	input wire pcs_line_pkg::code_group_t	rx_group,
	input wire							rx_valid,
	input wire							link_up,
	output pcs_link_pkg::gmii_bus_t		rx_gmii_bus
);
	import pcs_line_pkg::*;
	import pcs_link_pkg::*;

	logic	in_frame;		// Between /S/ and /T/
	logic	is_start;
	logic	is_term;

	assign is_start = rx_group.is_ctl && (rx_group.data == k27_7);
	assign is_term = rx_group.is_ctl && (rx_group.data == k29_7);

	always_ff @(posedge clk_125mhz) begin
		if (reset) begin
			in_frame <= 1'b0;
			rx_gmii_bus.en <= 1'b0;
			rx_gmii_bus.er <= 1'b0;
		end else begin
			rx_gmii_bus.en <= 1'b0;
			rx_gmii_bus.er <= 1'b0;

			if (!link_up)
				in_frame <= 1'b0;			// Drop any frame in progress
			else if (rx_valid) begin
				if (!in_frame) begin
					if (is_start) begin
						in_frame <= 1'b1;
						rx_gmii_bus.en <= 1'b1;
						rx_gmii_bus.data <= gmii_preamble;	// /S/ becomes 55
					end
				end else if (is_term)
					in_frame <= 1'b0;
				else begin
					rx_gmii_bus.en <= 1'b1;
					rx_gmii_bus.er <= rx_group.is_ctl;		// Stray K character
					rx_gmii_bus.data <= rx_group.data;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- gig_basex_pcs.sv
`default_nettype none
`timescale 1ns/10ps

module gig_basex_pcs #(
	parameter pcs_link_pkg::timer_t link_timer_sgmii = pcs_link_pkg::link_timer_sgmii_default,
	parameter pcs_link_pkg::timer_t link_timer_basex = pcs_link_pkg::link_timer_basex_default
) (
	input wire							clk_125mhz,
	input wire							reset,
	input wire							sgmii_mode,		// 1 = SGMII, 0 = 1000BASE-X

	// SERDES receive, average rate at most 125 MHz
	input wire							rx_clk,
	input wire							rx_data_valid,
	input wire pcs_line_pkg::code_group_t	rx_group,

	// Status
	output logic						link_up,
	output pcs_link_pkg::lspeed_t		link_speed,
	output pcs_link_pkg::gmii_bus_t		rx_gmii_bus,
	output logic						rx_overflow,	// rx_clk domain

	// SERDES transmit
	output logic						tx_clk,
	output pcs_line_pkg::code_group_t	tx_group
);
	import pcs_line_pkg::*;

	code_group_t	fifo_group;			// Receive stream in clk_125mhz
	logic			fifo_valid;
	config_word_t	partner_cfg;
	logic			cfg_valid;
	logic			idle_seen;
	config_word_t	tx_cfg;
	logic			send_config;

	assign tx_clk = clk_125mhz;		// TX runs on the core clock

	//////////////////////////////////////////////////////////////////////
	// Receive path

	rx_cdc_fifo #(.depth(32)) rx_fifo (
		.wr_clk(rx_clk), .wr_en(rx_data_valid), .wr_data(rx_group),
		.rd_clk(clk_125mhz), .reset(reset),
		.rd_data(fifo_group), .rd_valid(fifo_valid), .overflow(rx_overflow)
	);

	rx_ordered_set_parser os_parser (
		.clk_125mhz(clk_125mhz), .reset(reset),
		.rx_group(fifo_group), .rx_valid(fifo_valid), .link_up(link_up),
		.partner_cfg(partner_cfg), .cfg_valid(cfg_valid), .idle_seen(idle_seen)
	);

	rx_frame_decoder frame_dec (
		.clk_125mhz(clk_125mhz), .reset(reset),
		.rx_group(fifo_group), .rx_valid(fifo_valid), .link_up(link_up),
		.rx_gmii_bus(rx_gmii_bus)
	);

	//////////////////////////////////////////////////////////////////////
	// Autonegotiation and transmit

	aneg_fsm #(
		.link_timer_sgmii(link_timer_sgmii),
		.link_timer_basex(link_timer_basex)
	) aneg (
		.clk_125mhz(clk_125mhz), .reset(reset), .sgmii_mode(sgmii_mode),
		.partner_cfg(partner_cfg), .cfg_valid(cfg_valid), .idle_seen(idle_seen),
		.tx_cfg(tx_cfg), .send_config(send_config),
		.link_up(link_up), .link_speed(link_speed)
	);

	tx_code_gen tx_gen (
		.clk_125mhz(clk_125mhz), .reset(reset),
		.tx_cfg(tx_cfg), .send_config(send_config), .tx_group(tx_group)
	);

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter real period = 8.0		// ns
) (
	output logic	clk
);

	// Free running, starts low
	initial begin
		clk = 1'b0;
		forever #(period / 2.0) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- tb_gig_basex_pcs.sv
`default_nettype none
`timescale 1ns/10ps

module tb_gig_basex_pcs;
	import pcs_line_pkg::*;
	import pcs_link_pkg::*;

	localparam int timer_sgmii = 50;		// Short link timers for simulation
	localparam int timer_basex = 80;
	localparam int timeout_cycles = 20000;	// Tests need about 1200, rest is margin

	typedef enum {pm_silent, pm_config, pm_idle} partner_mode_t;

	logic			clk_125mhz;
	logic			rx_clk;				// SERDES recovered clock, 156 MHz
	logic			reset;
	logic			sgmii_mode;
	logic			rx_data_valid;
	code_group_t	rx_group;
	logic			link_up;
	lspeed_t		link_speed;
	gmii_bus_t		rx_gmii_bus;
	logic			rx_overflow;
	logic			tx_clk;
	code_group_t	tx_group;

	// Link partner state
	partner_mode_t	partner_mode = pm_silent;
	config_word_t	partner_word = '0;
	code_group_t	frame_q [$];		// Groups that go out before the next set

	gmii_bus_t		gmii_q [$];			// Bytes seen on the GMII side
	gmii_bus_t		exp_q [$];
	integer			seed = 67;
	int				cycle_cnt = 0;
	int				reset_cycle = 0;	// Cycle where reset was released
	int				err_cnt = 0;
	int				pass_cnt = 0;
	int				fail_cnt = 0;
	logic			overflow_seen = 1'b0;

	tb_clock_gen #(.period(8.0)) core_clk (.clk(clk_125mhz));
	tb_clock_gen #(.period(6.4)) serdes_clk (.clk(rx_clk));

	gig_basex_pcs #(
		.link_timer_sgmii(timer_sgmii),
		.link_timer_basex(timer_basex)
	) dut (
		.clk_125mhz(clk_125mhz), .reset(reset), .sgmii_mode(sgmii_mode),
		.rx_clk(rx_clk), .rx_data_valid(rx_data_valid), .rx_group(rx_group),
		.link_up(link_up), .link_speed(link_speed), .rx_gmii_bus(rx_gmii_bus),
		.rx_overflow(rx_overflow), .tx_clk(tx_clk), .tx_group(tx_group)
	);

	//////////////////////////////////////////////////////////////////////
	// Helpers

	function automatic code_group_t k_group(input byte_t d);
		code_group_t g;
		g.is_ctl = 1'b1;
		g.data = d;
		return g;
	endfunction

	function automatic code_group_t d_group(input byte_t d);
		code_group_t g;
		g.is_ctl = 1'b0;
		g.data = d;
		return g;
	endfunction

	function automatic gmii_bus_t make_gmii(input logic er, input byte_t d);
		gmii_bus_t b;
		b.en = 1'b1;
		b.er = er;
		b.data = d;
		return b;
	endfunction

	task automatic report_failure(input string what);
		$display("Failure at %0t: %s", $time, what);
		err_cnt++;
	endtask

	task automatic check_cfg(input string name, input config_word_t got,
		input config_word_t exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_speed(input string name, input lspeed_t got, input lspeed_t exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %b (%s), expected %b (%s)", $time, name,
				got, got.name(), exp, exp.name());
			err_cnt++;
		end
	endtask

	task automatic check_gmii(input string name, input gmii_bus_t got, input gmii_bus_t exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is en=%b er=%b data=%h, expected en=%b er=%b data=%h",
				$time, name, got.en, got.er, got.data, exp.en, exp.er, exp.data);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic end_test(input string name, input int start_err);
		if (err_cnt == start_err) begin
			pass_cnt++;
			$display("Test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("Test %s: %0d errors", name, err_cnt - start_err);
		end
	endtask

	// Reset takes 4 core cycles, the partner goes quiet first
	task automatic apply_reset(input logic sgmii, input int settle);
		partner_mode = pm_silent;
		repeat (settle) @(posedge clk_125mhz);		// Let the FIFO drain
		if (reset !== 1'b1) begin
			@(posedge clk_125mhz);
			#1;
			reset = 1'b1;
		end
		sgmii_mode = sgmii;
		repeat (4) @(posedge clk_125mhz);
		#1;
		reset = 1'b0;
		reset_cycle = cycle_cnt;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Link partner on the SERDES side

	// One group per call, random gaps keep the rate near 117 MHz
	task automatic send_group(input code_group_t g);
		logic go;
		go = 1'b0;
		while (!go) begin
			@(posedge rx_clk);
			#1;
			go = (($random(seed) & 7) < 6);
			rx_data_valid = go;
			if (go)
				rx_group = g;
		end
	endtask

	task automatic send_config_set(input byte_t hdr, input config_word_t w);
		send_group(k_group(k28_5));
		send_group(d_group(hdr));
		send_group(d_group(w[7:0]));		// Low byte first
		send_group(d_group(w[15:8]));
	endtask

	initial begin : partner
		forever begin
			if (frame_q.size() != 0)
				send_group(frame_q.pop_front());
			else begin
				case (partner_mode)
					pm_config: begin
						send_config_set(d21_5, partner_word);	// /C1/
						send_config_set(d2_2, partner_word);	// /C2/
					end
					pm_idle: begin
						send_group(k_group(k28_5));				// /I2/
						send_group(d_group(d16_2));
					end
					default: begin
						@(posedge rx_clk);
						#1;
						rx_data_valid = 1'b0;
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Monitors

	always @(negedge clk_125mhz)
		if (rx_gmii_bus.en === 1'b1)
			gmii_q.push_back(rx_gmii_bus);

	always @(negedge rx_clk)
		if (rx_overflow === 1'b1)
			overflow_seen = 1'b1;

	always @(posedge clk_125mhz) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("sim failed");
			$finish;
		end
	end

	// Next TX ordered set; word stays zero for idles
	task automatic read_tx_set(output byte_t hdr, output config_word_t word);
		word = '0;
		@(negedge clk_125mhz);
		while (!(tx_group.is_ctl === 1'b1 && tx_group.data == k28_5))
			@(negedge clk_125mhz);
		@(negedge clk_125mhz);
		hdr = tx_group.data;
		if (tx_group.is_ctl !== 1'b0)
			hdr = 8'h00;						// K character, no valid header
		else if (hdr == d21_5 || hdr == d2_2) begin
			@(negedge clk_125mhz);
			word[7:0] = tx_group.data;
			@(negedge clk_125mhz);
			word[15:8] = tx_group.data;
		end
	endtask

	task automatic await_tx_cfg(input config_word_t exp, input int deadline);
		byte_t hdr;
		config_word_t word;
		read_tx_set(hdr, word);
		while (word !== exp && cycle_cnt < deadline)
			read_tx_set(hdr, word);
		check_cfg("tx config word", word, exp);
	endtask

	// Config sets when want_cfg is set, else /I2/ idles
	task automatic await_tx_mode(input logic want_cfg, input int deadline);
		byte_t hdr;
		config_word_t word;
		logic done;
		read_tx_set(hdr, word);
		done = want_cfg ? (hdr == d21_5 || hdr == d2_2) : (hdr == d16_2);
		while (!done && cycle_cnt < deadline) begin
			read_tx_set(hdr, word);
			done = want_cfg ? (hdr == d21_5 || hdr == d2_2) : (hdr == d16_2);
		end
		if (!done)
			report_failure(want_cfg ? "TX did not return to /C/ sets in time" :
				"TX did not switch to /I2/ idles in time");
	endtask

	task automatic await_link(input logic level, input int deadline);
		while (link_up !== level && cycle_cnt < deadline)
			@(negedge clk_125mhz);
		check_bit("link_up", link_up, level);
	endtask

	// Compares the collected GMII bytes with exp_q
	task automatic expect_frame(input string name, input int deadline);
		int n;
		n = exp_q.size();
		while (gmii_q.size() < n && cycle_cnt < deadline)
			@(negedge clk_125mhz);
		repeat (8) @(negedge clk_125mhz);			// Catch stray trailing bytes
		if (gmii_q.size() != n)
			report_failure($sformatf("%s gave %0d GMII bytes instead of %0d",
				name, gmii_q.size(), n));
		for (int i = 0; i < n && i < gmii_q.size(); i++)
			check_gmii($sformatf("rx_gmii_bus byte %0d", i), gmii_q[i], exp_q[i]);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests

	task automatic test_after_reset();
		int start_err;
		byte_t hdr_a;
		byte_t hdr_b;
		config_word_t word_a;
		config_word_t word_b;
		start_err = err_cnt;
		check_bit("link_up", link_up, 1'b0);
		read_tx_set(hdr_a, word_a);
		read_tx_set(hdr_b, word_b);
		if (!((hdr_a == d21_5 && hdr_b == d2_2) || (hdr_a == d2_2 && hdr_b == d21_5)))
			report_failure("TX sets after reset do not alternate between /C1/ and /C2/");
		check_cfg("tx config word", word_a, 16'h0000);
		check_cfg("tx config word", word_b, 16'h0000);

		// TX clock follows the core clock
		@(posedge clk_125mhz);
		#1;
		check_bit("tx_clk", tx_clk, 1'b1);
		@(negedge clk_125mhz);
		#1;
		check_bit("tx_clk", tx_clk, 1'b0);
		end_test("after_reset", start_err);
	endtask

	// Restart then ability, within two link timers of reset
	task automatic test_ability(input string name, input config_word_t exp);
		int start_err;
		int timer;
		start_err = err_cnt;
		timer = sgmii_mode ? timer_sgmii : timer_basex;
		await_tx_cfg(exp, reset_cycle + 2 * timer + 8);
		end_test(name, start_err);
	endtask

	task automatic test_basex_negotiation();
		int start_err;
		start_err = err_cnt;
		partner_word = 16'h01a0;					// Full duplex plus pause bits
		partner_mode = pm_config;
		await_tx_cfg(16'h4020, cycle_cnt + 2 * timer_basex);
		partner_word = 16'h41a0;					// Same word, ACK set
		await_tx_mode(1'b0, cycle_cnt + 2 * timer_basex + 32);
		partner_mode = pm_idle;
		await_link(1'b1, cycle_cnt + 3 * timer_basex);
		check_speed("link_speed", link_speed, link_speed_1000m);
		end_test("basex_negotiation", start_err);
	endtask

	task automatic test_sgmii_negotiation();
		int start_err;
		start_err = err_cnt;
		partner_word = 16'hc401;					// Link, ACK, 100M, SGMII
		partner_mode = pm_config;
		await_tx_mode(1'b0, cycle_cnt + 3 * timer_sgmii + 64);
		partner_mode = pm_idle;
		await_link(1'b1, cycle_cnt + 3 * timer_sgmii);
		check_speed("link_speed", link_speed, link_speed_100m);
		end_test("sgmii_negotiation", start_err);
	endtask

	task automatic test_frame_receive();
		int start_err;
		logic [31:0] r;
		byte_t d;
		start_err = err_cnt;

		// Random payload, /S/ shows up as the 55 preamble byte
		gmii_q.delete();
		exp_q.delete();
		exp_q.push_back(make_gmii(1'b0, 8'h55));
		frame_q.push_back(k_group(k27_7));
		for (int i = 0; i < 5; i++) begin
			r = $random(seed);
			d = r[7:0];
			frame_q.push_back(d_group(d));
			exp_q.push_back(make_gmii(1'b0, d));
		end
		frame_q.push_back(k_group(k29_7));
		expect_frame("first frame", cycle_cnt + 200);

		// Comma inside the frame is flagged
		gmii_q.delete();
		exp_q.delete();
		exp_q.push_back(make_gmii(1'b0, 8'h55));
		exp_q.push_back(make_gmii(1'b0, 8'h11));
		exp_q.push_back(make_gmii(1'b1, k28_5));
		exp_q.push_back(make_gmii(1'b0, 8'h22));
		exp_q.push_back(make_gmii(1'b0, 8'h33));
		frame_q.push_back(k_group(k27_7));
		frame_q.push_back(d_group(8'h11));
		frame_q.push_back(k_group(k28_5));
		frame_q.push_back(d_group(8'h22));		// Not a /C/ or /I/ header
		frame_q.push_back(d_group(8'h33));
		frame_q.push_back(k_group(k29_7));
		expect_frame("second frame", cycle_cnt + 200);
		end_test("frame_receive", start_err);
	endtask

	task automatic test_partner_restart();
		int start_err;
		start_err = err_cnt;
		partner_word = 16'h0000;
		partner_mode = pm_config;
		await_link(1'b0, cycle_cnt + 64);
		await_tx_mode(1'b1, cycle_cnt + 32);
		end_test("partner_restart", start_err);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sequence

	initial begin
		reset = 1'b1;
		sgmii_mode = 1'b0;
		rx_data_valid = 1'b0;
		rx_group = '0;

		apply_reset(1'b0, 0);
		test_after_reset();
		test_ability("ability_basex", 16'h0020);	// Full duplex only
		test_basex_negotiation();

		apply_reset(1'b1, 20);				// Same DUT in SGMII mode
		test_ability("ability_sgmii", 16'h4001);	// ACK plus SGMII marker
		test_sgmii_negotiation();
		test_frame_receive();
		test_partner_restart();

		if (overflow_seen)
			report_failure("receive FIFO overflowed");
		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
pcs_line_pkg.sv
pcs_link_pkg.sv
rx_cdc_fifo.sv
rx_ordered_set_parser.sv
aneg_fsm.sv
tx_code_gen.sv
rx_frame_decoder.sv
gig_basex_pcs.sv
tb_clock_gen.sv
tb_gig_basex_pcs.sv
